/* all.f */
rtl/dma_desc_pkg.sv
rtl/dma_bus_pkg.sv
rtl/dma_slot_if.sv
rtl/dma_regs.sv
rtl/dma_job_ctrl.sv
rtl/dma_slot_engine.sv
rtl/dma_top.sv
testbench/wb_mem_model.sv
testbench/tb_dma_top.sv

/* rtl/dma_bus_pkg.sv */
// Bus and register map definitions
// Wishbone widths, host register offsets and CSR bits
package dma_bus_pkg;

   localparam int ADR_W = 32;
   localparam int DAT_W = 64;
   localparam int SEL_W = 8;

   localparam logic [1:0] REG_CSR    = 2'd0;
   localparam logic [1:0] REG_NDAR   = 2'd1;
   localparam logic [1:0] REG_DAR    = 2'd2;
   localparam logic [1:0] REG_INTCLR = 2'd3;

   localparam int CSR_EN     = 0;
   localparam int CSR_APPEND = 1;      // write 1 to request append
   localparam int CSR_BUSY   = 2;      // read only
   localparam int CSR_ERR    = 3;      // sticky, write 1 to clear

endpackage

/* rtl/dma_desc_pkg.sv */
// DMA descriptor definitions
// beat layout, control word bit positions and the job controller states
package dma_desc_pkg;

   localparam int DESC_BEATS  = 4;     // 64-bit beats per descriptor
   localparam int DC_LEN_W    = 7;     // transfer length, dc[6:0]
   localparam int DC_WB_BIT   = 7;     // status write-back request
   localparam int DC_LINK_BIT = 14;    // another descriptor follows
   localparam int DC_INT_BIT  = 15;    // interrupt on completion

   localparam logic [7:0] WB_DONE_CODE = 8'h01;

   // beat 0 of a descriptor
   typedef struct packed {
      logic [31:0] ctl_adr;            // status write-back address
      logic [31:0] next_adr;           // next descriptor
   } desc_link_t;

   // beat 1 of a descriptor
   typedef struct packed {
      logic [39:0] rsvd;
      logic [23:0] dc;                 // control and count word
   } desc_count_t;

   typedef union packed {
      desc_link_t  link;
      desc_count_t cnt;
   } desc_beat_t;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_FETCH0,
      ST_NEXT0,
      ST_FETCH1,
      ST_WAIT0,
      ST_WB0,
      ST_DONE0,
      ST_WAIT1,
      ST_WB1,
      ST_DONE1,
      ST_NEXT1
   } ctrl_state_t;

endpackage

/* rtl/dma_job_ctrl.sv */
// DMA job controller
// Wishbone master that fetches 4-beat descriptors, hands them to two
// channel engines, writes back status and follows the descriptor chain.
// Slot 1 is fetched and started while slot 0 is still running.
`timescale 1ns/1ps

module dma_job_ctrl (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            enable_i,
   input  logic                            ndar_dirty_i,
   input  logic                            append_i,
   input  logic [dma_bus_pkg::ADR_W-1:3]   ndar_i,
   output logic                            dirty_clr_o,
   output logic                            append_clr_o,
   output logic                            int_set_o,
   output logic                            err_set_o,
   output logic                            dar_upd_o,
   output logic [dma_bus_pkg::ADR_W-1:3]   dar_val_o,
   output logic                            busy_o,
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [dma_bus_pkg::SEL_W-1:0]   wb_sel_o,
   output logic [dma_bus_pkg::ADR_W-1:0]   wb_adr_o,
   output logic [dma_bus_pkg::DAT_W-1:0]   wb_dat_o,
   input  logic [dma_bus_pkg::DAT_W-1:0]   wb_dat_i,
   input  logic                            wb_ack_i,
   input  logic                            wb_err_i,
   dma_slot_if.ctrl                        slot0,
   dma_slot_if.ctrl                        slot1,
   output dma_desc_pkg::ctrl_state_t       state_o
);

   dma_desc_pkg::ctrl_state_t state_q, state_d;
   dma_desc_pkg::desc_beat_t  beat_in;

   logic                          cyc_q, we_q, append_mode_q;
   logic                          done0_q, done1_q;
   logic [1:0]                    beat_q;
   logic [dma_bus_pkg::ADR_W-1:3] adr_q, last_q, next_q;
   logic [dma_bus_pkg::ADR_W-1:3] ctl0_q, ctl1_q, desc0_q, desc1_q;
   logic [23:0]                   dc0_q, dc1_q;
   logic                          launch, launch_we, bus_end, abort;
   logic                          fetch_ack0, fetch_ack1;
   logic [dma_bus_pkg::ADR_W-1:3] launch_adr;

   assign beat_in    = wb_dat_i;
   assign abort      = cyc_q && wb_err_i;
   assign bus_end    = cyc_q && wb_ack_i &&
                       (we_q || beat_q == 2'(dma_desc_pkg::DESC_BEATS - 1));
   assign fetch_ack0 = state_q == dma_desc_pkg::ST_FETCH0 && wb_ack_i;
   assign fetch_ack1 = state_q == dma_desc_pkg::ST_FETCH1 && wb_ack_i;

   // Wishbone master outputs
   assign wb_cyc_o = cyc_q;
   assign wb_stb_o = cyc_q;                     // stb follows cyc for the burst
   assign wb_we_o  = we_q;
   assign wb_sel_o = '1;
   assign wb_adr_o = {adr_q, 3'b000};
   assign wb_dat_o = {24'h0, dma_desc_pkg::WB_DONE_CODE,
                      (state_q == dma_desc_pkg::ST_WB1) ? slot1.cycles : slot0.cycles};

   // register link strobes
   assign dirty_clr_o  = state_q == dma_desc_pkg::ST_IDLE && enable_i && ndar_dirty_i;
   assign append_clr_o = state_q == dma_desc_pkg::ST_NEXT0 && append_mode_q;
   assign err_set_o    = abort;
   assign dar_upd_o    = state_q == dma_desc_pkg::ST_DONE0 || state_q == dma_desc_pkg::ST_DONE1;
   assign dar_val_o    = (state_q == dma_desc_pkg::ST_DONE1) ? desc1_q : desc0_q;
   assign int_set_o    = (state_q == dma_desc_pkg::ST_DONE0 && dc0_q[dma_desc_pkg::DC_INT_BIT]) ||
                         (state_q == dma_desc_pkg::ST_DONE1 && dc1_q[dma_desc_pkg::DC_INT_BIT]);
   assign busy_o       = state_q != dma_desc_pkg::ST_IDLE;
   assign state_o      = state_q;

   // slot 0 is not loaded on an append re-read
   assign slot0.load_we   = fetch_ack0 && !append_mode_q;
   assign slot0.load_beat = beat_q;
   assign slot0.load_dat  = wb_dat_i;
   assign slot0.start     = state_q == dma_desc_pkg::ST_NEXT0 && !append_mode_q;
   assign slot0.clear     = abort || state_q == dma_desc_pkg::ST_DONE0;
   assign slot1.load_we   = fetch_ack1;
   assign slot1.load_beat = beat_q;
   assign slot1.load_dat  = wb_dat_i;
   assign slot1.start     = fetch_ack1 && bus_end;   // runs while slot 0 is awaited
   assign slot1.clear     = abort || state_q == dma_desc_pkg::ST_DONE1;

   always_comb begin
      state_d    = state_q;
      launch     = 1'b0;
      launch_we  = 1'b0;
      launch_adr = next_q;
      case (state_q)
         dma_desc_pkg::ST_IDLE:
            if (enable_i && (ndar_dirty_i || append_i)) begin
               launch     = 1'b1;
               launch_adr = ndar_dirty_i ? ndar_i : last_q;   // append re-reads DAR
               state_d    = dma_desc_pkg::ST_FETCH0;
            end
         dma_desc_pkg::ST_FETCH0:
            if (bus_end)
               state_d = dma_desc_pkg::ST_NEXT0;
         dma_desc_pkg::ST_NEXT0:
            if (dc0_q[dma_desc_pkg::DC_LINK_BIT]) begin
               launch  = 1'b1;
               state_d = append_mode_q ? dma_desc_pkg::ST_FETCH0 : dma_desc_pkg::ST_FETCH1;
            end else begin
               state_d = append_mode_q ? dma_desc_pkg::ST_IDLE : dma_desc_pkg::ST_WAIT0;
            end
         dma_desc_pkg::ST_FETCH1:
            if (bus_end)
               state_d = dma_desc_pkg::ST_WAIT0;
         dma_desc_pkg::ST_WAIT0:
            if (done0_q) begin
               if (dc0_q[dma_desc_pkg::DC_WB_BIT]) begin
                  launch     = 1'b1;
                  launch_we  = 1'b1;
                  launch_adr = ctl0_q;
                  state_d    = dma_desc_pkg::ST_WB0;
               end else begin
                  state_d = dma_desc_pkg::ST_DONE0;
               end
            end
         dma_desc_pkg::ST_WB0:
            if (bus_end)
               state_d = dma_desc_pkg::ST_DONE0;
         dma_desc_pkg::ST_DONE0:
            state_d = dc0_q[dma_desc_pkg::DC_LINK_BIT] ? dma_desc_pkg::ST_WAIT1
                                                        : dma_desc_pkg::ST_IDLE;
         dma_desc_pkg::ST_WAIT1:
            if (done1_q) begin
               if (dc1_q[dma_desc_pkg::DC_WB_BIT]) begin
                  launch     = 1'b1;
                  launch_we  = 1'b1;
                  launch_adr = ctl1_q;
                  state_d    = dma_desc_pkg::ST_WB1;
               end else begin
                  state_d = dma_desc_pkg::ST_DONE1;
               end
            end
         dma_desc_pkg::ST_WB1:
            if (bus_end)
               state_d = dma_desc_pkg::ST_DONE1;
         dma_desc_pkg::ST_DONE1:
            state_d = dc1_q[dma_desc_pkg::DC_LINK_BIT] ? dma_desc_pkg::ST_NEXT1
                                                        : dma_desc_pkg::ST_IDLE;
         dma_desc_pkg::ST_NEXT1: begin
            launch  = 1'b1;                     // follow link of slot 1
            state_d = dma_desc_pkg::ST_FETCH0;
         end
         default: state_d = dma_desc_pkg::ST_IDLE;
      endcase
      if (abort)
         state_d = dma_desc_pkg::ST_IDLE;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q       <= dma_desc_pkg::ST_IDLE;
         cyc_q         <= 1'b0;
         we_q          <= 1'b0;
         append_mode_q <= 1'b0;
         done0_q       <= 1'b0;
         done1_q       <= 1'b0;
         last_q        <= '0;
      end else begin
         state_q <= state_d;
         if (launch) begin
            cyc_q <= 1'b1;
            we_q  <= launch_we;
         end else if (bus_end || abort) begin
            cyc_q <= 1'b0;
         end
         if (state_q == dma_desc_pkg::ST_IDLE && launch)
            append_mode_q <= !ndar_dirty_i;
         else if (state_q == dma_desc_pkg::ST_NEXT0 || abort)
            append_mode_q <= 1'b0;
         // engine done strobes are held until the FSM gets to them
         if (abort || (state_q == dma_desc_pkg::ST_WAIT0 && done0_q))
            done0_q <= 1'b0;
         else if (slot0.done)
            done0_q <= 1'b1;
         if (abort || (state_q == dma_desc_pkg::ST_WAIT1 && done1_q))
            done1_q <= 1'b0;
         else if (slot1.done)
            done1_q <= 1'b1;
         if (dar_upd_o)
            last_q <= dar_val_o;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (launch) begin
         adr_q  <= launch_adr;
         beat_q <= 2'd0;
      end else if (cyc_q && wb_ack_i) begin
         adr_q  <= adr_q + 1'b1;                // next 8-byte beat
         beat_q <= beat_q + 1'b1;
      end
      if (fetch_ack0 && beat_q == 2'd0) begin
         next_q  <= beat_in.link.next_adr[dma_bus_pkg::ADR_W-1:3];
         ctl0_q  <= beat_in.link.ctl_adr[dma_bus_pkg::ADR_W-1:3];
         desc0_q <= adr_q;
      end
      if (fetch_ack0 && beat_q == 2'd1)
         dc0_q <= beat_in.cnt.dc;
      if (fetch_ack1 && beat_q == 2'd0) begin
         next_q  <= beat_in.link.next_adr[dma_bus_pkg::ADR_W-1:3];
         ctl1_q  <= beat_in.link.ctl_adr[dma_bus_pkg::ADR_W-1:3];
         desc1_q <= adr_q;
      end
      if (fetch_ack1 && beat_q == 2'd1)
         dc1_q <= beat_in.cnt.dc;
   end

endmodule

/* rtl/dma_regs.sv */
// DMA host register file
// CSR, next descriptor pointer with dirty flag, append request,
// last completed descriptor and the interrupt flag
`timescale 1ns/1ps

module dma_regs (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            reg_we_i,
   input  logic [1:0]                      reg_adr_i,
   input  logic [31:0]                     reg_dat_i,
   output logic [31:0]                     reg_dat_o,
   input  logic                            dirty_clr_i,
   input  logic                            append_clr_i,
   input  logic                            int_set_i,
   input  logic                            err_set_i,
   input  logic                            dar_upd_i,
   input  logic [dma_bus_pkg::ADR_W-1:3]   dar_val_i,
   input  logic                            busy_i,
   output logic                            enable_o,
   output logic                            ndar_dirty_o,
   output logic                            append_o,
   output logic [dma_bus_pkg::ADR_W-1:3]   ndar_o,
   output logic                            wb_int_o
);

   logic wr_csr, wr_ndar, wr_intclr;
   logic err_q;
   logic [dma_bus_pkg::ADR_W-1:3] dar_q;

   assign wr_csr    = reg_we_i && reg_adr_i == dma_bus_pkg::REG_CSR;
   assign wr_ndar   = reg_we_i && reg_adr_i == dma_bus_pkg::REG_NDAR;
   assign wr_intclr = reg_we_i && reg_adr_i == dma_bus_pkg::REG_INTCLR;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         enable_o     <= 1'b0;
         ndar_dirty_o <= 1'b0;
         append_o     <= 1'b0;
         ndar_o       <= '0;
         dar_q        <= '0;
         err_q        <= 1'b0;
         wb_int_o     <= 1'b0;
      end else begin
         if (wr_csr)
            enable_o <= reg_dat_i[dma_bus_pkg::CSR_EN];
         if (wr_csr && reg_dat_i[dma_bus_pkg::CSR_APPEND])
            append_o <= 1'b1;
         else if (append_clr_i)
            append_o <= 1'b0;
         if (wr_ndar) begin
            ndar_o       <= reg_dat_i[dma_bus_pkg::ADR_W-1:3];
            ndar_dirty_o <= 1'b1;               // host write wins over clear
         end else if (dirty_clr_i) begin
            ndar_dirty_o <= 1'b0;
         end
         if (err_set_i)
            err_q <= 1'b1;
         else if (wr_csr && reg_dat_i[dma_bus_pkg::CSR_ERR])
            err_q <= 1'b0;
         if (int_set_i || err_set_i)
            wb_int_o <= 1'b1;
         else if (wr_intclr)
            wb_int_o <= 1'b0;
         if (dar_upd_i)
            dar_q <= dar_val_i;
      end
   end

   always_comb begin
      reg_dat_o = '0;
      case (reg_adr_i)
         dma_bus_pkg::REG_CSR: begin
            reg_dat_o[dma_bus_pkg::CSR_EN]     = enable_o;
            reg_dat_o[dma_bus_pkg::CSR_APPEND] = append_o;
            reg_dat_o[dma_bus_pkg::CSR_BUSY]   = busy_i;
            reg_dat_o[dma_bus_pkg::CSR_ERR]    = err_q;
         end
         dma_bus_pkg::REG_NDAR: reg_dat_o = {ndar_o, 3'b000};
         dma_bus_pkg::REG_DAR:  reg_dat_o = {dar_q, 3'b000};
         default:               reg_dat_o[0] = wb_int_o;   // interrupt pending
      endcase
   end

endmodule

/* rtl/dma_slot_engine.sv */
// DMA channel engine
// takes the count word of a loaded descriptor, counts out its length
// after start, then pulses done and holds the cycles it used
`timescale 1ns/1ps

module dma_slot_engine (
   input  logic         wb_clk_i,
   input  logic         wb_rst_i,
   dma_slot_if.engine   slot
);

   dma_desc_pkg::desc_beat_t          beat;
   logic [dma_desc_pkg::DC_LEN_W-1:0] len_q;
   logic [dma_desc_pkg::DC_LEN_W-1:0] remain_q;
   logic                              loaded_q, running_q, done_q;
   logic [31:0]                       cyc_q;
   logic                              go, load_cnt;

   assign beat     = slot.load_dat;
   assign load_cnt = slot.load_we && slot.load_beat == 2'd1;
   assign go       = slot.start && loaded_q;    // start without a job is ignored

   assign slot.done   = done_q;
   assign slot.cycles = cyc_q;

   always_ff @(posedge wb_clk_i) begin
      if (load_cnt)
         len_q <= beat.cnt.dc[dma_desc_pkg::DC_LEN_W-1:0];
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         loaded_q  <= 1'b0;
         running_q <= 1'b0;
         done_q    <= 1'b0;
         remain_q  <= '0;
         cyc_q     <= '0;
      end else begin
         done_q <= 1'b0;
         if (slot.clear) begin
            loaded_q  <= 1'b0;
            running_q <= 1'b0;
         end else begin
            if (go) begin
               remain_q  <= len_q;
               cyc_q     <= 32'd1;
               running_q <= len_q != '0;
               done_q    <= len_q == '0;        // zero length ends next cycle
            end else if (running_q) begin
               remain_q <= remain_q - 1'b1;
               cyc_q    <= cyc_q + 1'b1;
               if (remain_q == 1) begin
                  running_q <= 1'b0;
                  done_q    <= 1'b1;
               end
            end
            if (load_cnt)
               loaded_q <= 1'b1;
            else if (go)
               loaded_q <= 1'b0;
         end
      end
   end

endmodule

/* rtl/dma_slot_if.sv */
// Controller to channel engine link
// carries descriptor beats and start/clear strobes down, done and
// the measured cycle count back up
`timescale 1ns/1ps

interface dma_slot_if;

   logic                          load_we;    // one per descriptor beat
   logic [1:0]                    load_beat;
   logic [dma_bus_pkg::DAT_W-1:0] load_dat;
   logic                          start;
   logic                          clear;
   logic                          done;
   logic [31:0]                   cycles;     // valid from done to next start

   modport ctrl (
      output load_we, load_beat, load_dat, start, clear,
      input  done, cycles
   );

   modport engine (
      input  load_we, load_beat, load_dat, start, clear,
      output done, cycles
   );

endinterface

/* rtl/dma_top.sv */
// DMA job controller top level
// host register port, Wishbone master and two channel engine slots
`timescale 1ns/1ps

module dma_top (
   input  logic                            wb_clk_i,
   input  logic                            wb_rst_i,
   input  logic                            reg_we_i,
   input  logic [1:0]                      reg_adr_i,
   input  logic [31:0]                     reg_dat_i,
   output logic [31:0]                     reg_dat_o,
   output logic                            wb_cyc_o,
   output logic                            wb_stb_o,
   output logic                            wb_we_o,
   output logic [dma_bus_pkg::SEL_W-1:0]   wb_sel_o,
   output logic [dma_bus_pkg::ADR_W-1:0]   wb_adr_o,
   output logic [dma_bus_pkg::DAT_W-1:0]   wb_dat_o,
   input  logic [dma_bus_pkg::DAT_W-1:0]   wb_dat_i,
   input  logic                            wb_ack_i,
   input  logic                            wb_err_i,
   output logic                            wb_int_o,
   output logic                            busy_o,
   output dma_desc_pkg::ctrl_state_t       state_o
);

   logic                          enable, ndar_dirty, append;
   logic [dma_bus_pkg::ADR_W-1:3] ndar, dar_val;
   logic                          dirty_clr, append_clr, int_set, err_set, dar_upd;

   dma_slot_if slot0_if ();
   dma_slot_if slot1_if ();

   dma_regs i_dma_regs (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .reg_we_i     (reg_we_i),
      .reg_adr_i    (reg_adr_i),
      .reg_dat_i    (reg_dat_i),
      .reg_dat_o    (reg_dat_o),
      .dirty_clr_i  (dirty_clr),
      .append_clr_i (append_clr),
      .int_set_i    (int_set),
      .err_set_i    (err_set),
      .dar_upd_i    (dar_upd),
      .dar_val_i    (dar_val),
      .busy_i       (busy_o),
      .enable_o     (enable),
      .ndar_dirty_o (ndar_dirty),
      .append_o     (append),
      .ndar_o       (ndar),
      .wb_int_o     (wb_int_o)
   );

   dma_job_ctrl i_dma_job_ctrl (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .enable_i     (enable),
      .ndar_dirty_i (ndar_dirty),
      .append_i     (append),
      .ndar_i       (ndar),
      .dirty_clr_o  (dirty_clr),
      .append_clr_o (append_clr),
      .int_set_o    (int_set),
      .err_set_o    (err_set),
      .dar_upd_o    (dar_upd),
      .dar_val_o    (dar_val),
      .busy_o       (busy_o),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o),
      .wb_we_o      (wb_we_o),
      .wb_sel_o     (wb_sel_o),
      .wb_adr_o     (wb_adr_o),
      .wb_dat_o     (wb_dat_o),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_i     (wb_ack_i),
      .wb_err_i     (wb_err_i),
      .slot0        (slot0_if.ctrl),
      .slot1        (slot1_if.ctrl),
      .state_o      (state_o)
   );

   dma_slot_engine i_slot0_engine (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .slot     (slot0_if.engine)
   );

   dma_slot_engine i_slot1_engine (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .slot     (slot1_if.engine)
   );

endmodule

/* testbench/tb_dma_top.sv */
// Testbench for the DMA job controller
// builds random descriptor chains in a Wishbone memory and checks
// write-backs, DAR, interrupts and the error path against a model
`timescale 1ns/1ps

module tb_dma_top;

   localparam int N_DESC  = 23;                // 1 + 12 + 4 + 6 descriptors
   localparam int TIMEOUT = N_DESC * 200 + 5000;

   logic        wb_clk_i, wb_rst_i, reg_we_i;
   logic [1:0]  reg_adr_i;
   logic [31:0] reg_dat_i, reg_dat_o, wb_adr_o;
   logic        wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i, wb_err_i, wb_int_o, busy_o;
   logic [7:0]  wb_sel_o;
   logic [63:0] wb_dat_o, wb_dat_i;
   logic        err_en;
   logic [31:0] err_adr;
   dma_desc_pkg::ctrl_state_t state_o;

   int cycle_cnt = 0;
   int n_err, n_tests, n_bad, test_err0, int_cnt;
   int d_len [N_DESC];
   bit d_wb  [N_DESC];
   bit d_int [N_DESC];

   dma_top i_dma_top (.*);

   wb_mem_model i_wb_mem_model (
      .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i),
      .wb_cyc_i (wb_cyc_o), .wb_stb_i (wb_stb_o), .wb_we_i (wb_we_o),
      .wb_sel_i (wb_sel_o), .wb_adr_i (wb_adr_o), .wb_dat_i (wb_dat_o),
      .wb_dat_o (wb_dat_i), .wb_ack_o (wb_ack_i), .wb_err_o (wb_err_i),
      .err_en_i (err_en),   .err_adr_i (err_adr)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #50 wb_clk_i = ~wb_clk_i;
   end

   always @(posedge wb_clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] desc_adr(int n);
      return 32'h0000_0200 + 32'(n) * 32;       // 4 beats of 8 bytes
   endfunction

   function automatic logic [31:0] ctl_adr(int n);
      return 32'h0000_1000 + 32'(n) * 8;
   endfunction

   function automatic logic [63:0] fill_word(int i);
      return {32'hc0de_0000 ^ 32'(i), ~32'(i)};
   endfunction

   task automatic wrong_value(string what, logic [63:0] got, logic [63:0] exp);
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
      n_err++;
   endtask

   task automatic write_reg(logic [1:0] adr, logic [31:0] dat);
      @(posedge wb_clk_i);
      reg_we_i  <= 1'b1;
      reg_adr_i <= adr;
      reg_dat_i <= dat;
      @(posedge wb_clk_i);
      reg_we_i  <= 1'b0;
   endtask

   task automatic read_reg(logic [1:0] adr, output logic [31:0] dat);
      @(posedge wb_clk_i);
      reg_adr_i <= adr;
      @(negedge wb_clk_i);
      dat = reg_dat_o;
   endtask

   // chain of descriptors first..first+count-1 with only the last one unlinked
   task automatic build_chain(int first, int count, bit allow_int);
      logic [23:0] dc;
      int          n;
      for (int k = 0; k < count; k++) begin
         n = first + k;
         d_len[n] = $urandom_range(0, 127);
         d_wb[n]  = $urandom_range(0, 1);
         d_int[n] = allow_int ? $urandom_range(0, 1) : 0;
         dc = 24'(d_len[n]);
         dc[dma_desc_pkg::DC_WB_BIT]   = d_wb[n];
         dc[dma_desc_pkg::DC_INT_BIT]  = d_int[n];
         dc[dma_desc_pkg::DC_LINK_BIT] = (k != count - 1);
         i_wb_mem_model.mem[desc_adr(n) >> 3]       = {ctl_adr(n), desc_adr(n + 1)};
         i_wb_mem_model.mem[(desc_adr(n) >> 3) + 1] = {40'h0, dc};
      end
   endtask

   task automatic start_chain(int first);
      write_reg(dma_bus_pkg::REG_NDAR, desc_adr(first));
      write_reg(dma_bus_pkg::REG_CSR, 32'h1 << dma_bus_pkg::CSR_EN);
   endtask

   // waits for busy to rise and fall and optionally counts and clears irqs
   task automatic wait_idle(bit clr_int);
      bit seen_busy;
      bit done;
      bit irq;
      bit bsy;
      dma_desc_pkg::ctrl_state_t st;
      seen_busy = 1'b0;
      done      = 1'b0;
      int_cnt   = 0;
      while (!done) begin
         @(negedge wb_clk_i);
         irq = wb_int_o;
         bsy = busy_o;
         st  = state_o;
         if (clr_int && irq) begin
            int_cnt++;
            write_reg(dma_bus_pkg::REG_INTCLR, 32'h1);
         end
         if (bsy) begin
            if (!seen_busy && st !== dma_desc_pkg::ST_FETCH0)
               wrong_value("state when busy rose", st, dma_desc_pkg::ST_FETCH0);
            seen_busy = 1'b1;
         end else if (seen_busy) begin
            if (st !== dma_desc_pkg::ST_IDLE)
               wrong_value("state when busy fell", st, dma_desc_pkg::ST_IDLE);
            done = 1'b1;
         end
      end
   endtask

   task automatic check_wb(int first, int last);
      logic [63:0] exp;
      int          w;
      for (int n = first; n <= last; n++) begin
         w   = ctl_adr(n) >> 3;
         exp = d_wb[n] ? {24'h0, dma_desc_pkg::WB_DONE_CODE, 32'(d_len[n] + 1)}
                       : fill_word(w);
         if (i_wb_mem_model.mem[w] !== exp)
            wrong_value($sformatf("status of descriptor %0d", n), i_wb_mem_model.mem[w], exp);
      end
   endtask

   task automatic check_dar(int n);
      logic [31:0] rd;
      read_reg(dma_bus_pkg::REG_DAR, rd);
      if (rd !== desc_adr(n))
         wrong_value("DAR", rd, desc_adr(n));
   endtask

   function automatic int int_sum(int first, int last);
      int s;
      s = 0;
      for (int n = first; n <= last; n++)
         s += d_int[n];
      return s;
   endfunction

   task automatic end_test(string name);
      n_tests++;
      if (n_err == test_err0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, n_err - test_err0);
         n_bad++;
      end
      test_err0 = n_err;
   endtask

   initial begin
      logic [31:0] rd;
      int          errk;
      rd = $urandom(32'hbedb_fcf9);
      wb_rst_i  = 1'b1;
      reg_we_i  = 1'b0;
      reg_adr_i = 2'd0;
      reg_dat_i = 32'h0;
      err_en    = 1'b0;
      err_adr   = 32'h0;
      n_err = 0;
      n_tests = 0;
      n_bad = 0;
      test_err0 = 0;
      for (int i = 0; i < 1024; i++)
         i_wb_mem_model.mem[i] = fill_word(i);
      repeat (10) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;

      @(negedge wb_clk_i);                     // reset values
      if (busy_o !== 1'b0 || wb_cyc_o !== 1'b0 || wb_int_o !== 1'b0)
         wrong_value("busy/cyc/int after reset", {busy_o, wb_cyc_o, wb_int_o}, 0);
      if (state_o !== dma_desc_pkg::ST_IDLE)
         wrong_value("state after reset", state_o, dma_desc_pkg::ST_IDLE);
      read_reg(dma_bus_pkg::REG_CSR, rd);
      if (rd !== 32'h0)
         wrong_value("CSR after reset", rd, 0);
      end_test("reset");

      build_chain(0, 1, 1'b1);
      d_int[0] = 1'b1;                         // interrupt needed to test INTCLR
      i_wb_mem_model.mem[(desc_adr(0) >> 3) + 1][dma_desc_pkg::DC_INT_BIT] = 1'b1;
      start_chain(0);
      wait_idle(1'b0);
      check_wb(0, 0);
      check_dar(0);
      if (wb_int_o !== d_int[0])
         wrong_value("interrupt of single descriptor", wb_int_o, d_int[0]);
      write_reg(dma_bus_pkg::REG_INTCLR, 32'h1);
      @(negedge wb_clk_i);
      if (wb_int_o !== 1'b0)
         wrong_value("interrupt after INTCLR", wb_int_o, 0);
      end_test("single descriptor");

      build_chain(1, 12, 1'b1);
      start_chain(1);
      wait_idle(1'b1);
      check_wb(1, 12);
      check_dar(12);
      if (int_cnt != int_sum(1, 12))
         wrong_value("interrupt count", int_cnt, int_sum(1, 12));
      end_test("chain of 12");

      build_chain(13, 4, 1'b1);
      i_wb_mem_model.mem[desc_adr(12) >> 3] = {ctl_adr(12), desc_adr(13)};
      i_wb_mem_model.mem[(desc_adr(12) >> 3) + 1][dma_desc_pkg::DC_LINK_BIT] = 1'b1;
      write_reg(dma_bus_pkg::REG_CSR,
                (32'h1 << dma_bus_pkg::CSR_EN) | (32'h1 << dma_bus_pkg::CSR_APPEND));
      wait_idle(1'b1);
      check_wb(12, 16);                        // re-read of 12 writes nothing
      check_dar(16);
      if (int_cnt != int_sum(13, 16))
         wrong_value("interrupt count after append", int_cnt, int_sum(13, 16));
      read_reg(dma_bus_pkg::REG_CSR, rd);
      if (rd !== (32'h1 << dma_bus_pkg::CSR_EN))
         wrong_value("CSR after append", rd, 32'h1 << dma_bus_pkg::CSR_EN);
      end_test("append");

      if (wb_int_o !== 1'b0)
         wrong_value("interrupt before bus error", wb_int_o, 0);
      errk = 2 * $urandom_range(1, 2);         // even index, fetched into slot 0
      build_chain(17, 6, 1'b0);
      @(posedge wb_clk_i);
      err_adr <= desc_adr(17 + errk);
      err_en  <= 1'b1;
      start_chain(17);
      wait_idle(1'b0);
      for (int n = 17 + errk; n < N_DESC; n++)
         d_wb[n] = 1'b0;                       // aborted and never written back
      check_wb(17, N_DESC - 1);
      check_dar(17 + errk - 1);
      read_reg(dma_bus_pkg::REG_CSR, rd);
      if (rd[dma_bus_pkg::CSR_ERR] !== 1'b1)
         wrong_value("CSR error bit", rd[dma_bus_pkg::CSR_ERR], 1);
      if (wb_int_o !== 1'b1 || wb_cyc_o !== 1'b0)
         wrong_value("int/cyc after bus error", {wb_int_o, wb_cyc_o}, 2'b10);
      end_test("bus error");

      $display("tests run %0d, tests with errors %0d, mismatches %0d", n_tests, n_bad, n_err);
      if (n_err == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* testbench/wb_mem_model.sv */
// Wishbone slave memory for the DMA testbench
// 64-bit words, random ack delay, err returned at one chosen address
`timescale 1ns/1ps

module wb_mem_model (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [7:0]  wb_sel_i,
   input  logic [31:0] wb_adr_i,
   input  logic [63:0] wb_dat_i,
   output logic [63:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   input  logic        err_en_i,
   input  logic [31:0] err_adr_i
);

   logic [63:0] mem [0:1023];                  // filled by the testbench
   logic [1:0]  delay_q;                       // wait states before next reply
   logic [9:0]  idx;

   assign idx = wb_adr_i[12:3];

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         wb_dat_o <= '0;
         delay_q  <= '0;
      end else begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         if (wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o) begin
            if (delay_q != 2'd0) begin
               delay_q <= delay_q - 1'b1;
            end else begin
               delay_q <= 2'($urandom_range(0, 3));
               if (err_en_i && wb_adr_i[31:3] == err_adr_i[31:3]) begin
                  wb_err_o <= 1'b1;             // no data phase on err
               end else begin
                  wb_ack_o <= 1'b1;
                  wb_dat_o <= mem[idx];
                  if (wb_we_i)
                     for (int b = 0; b < 8; b++)
                        if (wb_sel_i[b])
                           mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
               end
            end
         end
      end
   end

endmodule
